// File: project.f
verilog/rvv_pkg.sv
verilog/rvv_if.sv
verilog/rvv_cmd_queue.sv
verilog/rvv_decode_unit.sv
verilog/rvv_decode_ctrl.sv
verilog/rvv_decode.sv
verilog/rvv_uop_queue.sv
verilog/rvv_backend.sv
test/rvv_backend_assert.sv
test/rvv_backend_tb.sv

// File: test/rvv_backend_assert.sv
// protocol assertions for queue push, pop order and reset levels
// bind statements onto command queue, uop queue and decode control
`timescale 1ns/100ps
`default_nettype none

module rvv_backend_assert (
  input logic                           clk,
  input logic                           reset,
  input logic [rvv_pkg::NUM_DE_UOP-1:0] push,
  input logic                           full,
  input logic [1:0]                     pop,
  input logic                           level_high,
  input logic                           level_low
);

  // read by the testbench monitor
  int unsigned fail_count = 0;

  // nothing written into a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (reset) (|push) |-> !full)
    else begin
      $error("uop push while queue full");
      fail_count++;
    end

  // push bits form 0, 1, 3, 7, 15 only
  a_push_packed: assert property (@(posedge clk) disable iff (reset)
                                  (push & (push + 1'b1)) == '0)
    else begin
      $error("push bits have a gap");
      fail_count++;
    end

  // second pop only along with the first
  a_pop_order: assert property (@(posedge clk) disable iff (reset) pop[1] |-> pop[0])
    else begin
      $error("pop of entry 1 without entry 0");
      fail_count++;
    end

  // idle levels once reset has been seen
  a_reset_levels: assert property (@(posedge clk) reset |=> (level_high && !level_low))
    else begin
      $error("wrong level one cycle after reset");
      fail_count++;
    end

endmodule

// uop queue, empty after reset
bind rvv_uop_queue rvv_backend_assert i_uq_assert (
  .clk        (clk),
  .reset      (reset),
  .push       (uq.push),
  .full       (uq.fifo_full),
  .pop        (2'b00),
  .level_high (uop_empty),
  .level_low  (1'b0)
);

// command queue, not full and empty after reset
bind rvv_cmd_queue rvv_backend_assert i_cq_assert (
  .clk        (clk),
  .reset      (reset),
  .push       ('0),
  .full       (1'b0),
  .pop        (cq.pop),
  .level_high (cq.fifo_empty),
  .level_low  (cmd_full)
);

// decode control, no pop, no push, index cleared
bind rvv_decode_ctrl rvv_backend_assert i_ctrl_assert (
  .clk        (clk),
  .reset      (reset),
  .push       (uq.push),
  .full       (uq.fifo_full),
  .pop        (cq.pop),
  .level_high (1'b1),
  .level_low  ((|uop_index_remain) | (|cq.pop) | (|uq.push))
);

`default_nettype wire

// File: test/rvv_backend_tb.sv
// testbench for the vector backend front end
// uop stream reference model, compare on pop, timeouts
`timescale 1ns/100ps
`default_nettype none

module rvv_backend_tb;

  logic              clk;
  logic              reset;
  logic              cmd_push;
  rvv_pkg::rvv_cmd_t cmd_data;
  logic              uop_pop;
  logic              cmd_full;
  logic              uop_empty;
  rvv_pkg::rvv_uop_t uop_data;

  rvv_pkg::rvv_uop_t exp_q [$];
  string             test_name = "reset";
  int                pop_mode = 0;  // 0 hold, 1 every cycle, 2 random stalls
  int                stall_left;

  rvv_backend i_rvv_backend (
    .clk       (clk),
    .reset     (reset),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_data),
    .uop_pop   (uop_pop),
    .cmd_full  (cmd_full),
    .uop_empty (uop_empty),
    .uop_data  (uop_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // failures seen by the bound protocol checkers
  function automatic int unsigned assert_fails();
    return i_rvv_backend.i_uop_queue.i_uq_assert.fail_count +
           i_rvv_backend.i_cmd_queue.i_cq_assert.fail_count +
           i_rvv_backend.i_decode.i_decode_ctrl.i_ctrl_assert.fail_count;
  endfunction

  // expected uops of one accepted command
  function automatic void add_expected(input rvv_pkg::rvv_cmd_t c);
    int                n;
    int                epu;
    int                lo;
    rvv_pkg::rvv_uop_t u;
    n   = 1 << c.lmul;
    epu = rvv_pkg::VLENB >> c.sew;
    // illegal encodings vanish
    if (c.sew == 2'd3 || (c.vd % n) != 0 || (c.vs2 % n) != 0) begin
      return;
    end
    for (int k = 0; k < n; k++) begin
      lo = k * epu;
      // every element below vstart means a prestart uop
      if (c.vstart >= lo + epu) begin
        continue;
      end
      u.inst_class = c.inst_class;
      u.sew        = c.sew;
      u.vd         = 5'((c.vd + k) % 32);
      u.vs2        = 5'((c.vs2 + k) % 32);
      u.vs1        = 5'((c.vs1 + k) % 32);
      u.uop_index  = 3'(k);
      u.vstart     = (c.vstart > lo) ? 7'(c.vstart - lo) : 7'd0;
      u.last       = (k == n - 1);
      exp_q.push_back(u);
    end
  endfunction

  // register group aligned to lmul
  function automatic rvv_pkg::rvv_cmd_t make_cmd(input int cls, input int sew,
                                                 input int lmul, input int vstart);
    rvv_pkg::rvv_cmd_t c;
    int                n;
    n            = 1 << lmul;
    c.inst_class = rvv_pkg::inst_class_e'(cls);
    c.sew        = rvv_pkg::sew_t'(sew);
    c.lmul       = rvv_pkg::lmul_t'(lmul);
    c.vd         = rvv_pkg::vreg_t'(($urandom_range(0, 31) / n) * n);
    c.vs2        = rvv_pkg::vreg_t'(($urandom_range(0, 31) / n) * n);
    c.vs1        = rvv_pkg::vreg_t'($urandom_range(0, 31));
    c.vstart     = rvv_pkg::vstart_t'(vstart);
    return c;
  endfunction

  // mostly legal with some vstart and about one in eight with sew 3
  function automatic rvv_pkg::rvv_cmd_t rand_cmd();
    rvv_pkg::rvv_cmd_t c;
    int                vs;
    vs = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 127) : 0;
    c  = make_cmd($urandom_range(0, 3), $urandom_range(0, 2), $urandom_range(0, 3), vs);
    if ($urandom_range(0, 7) == 0) begin
      c.sew = 2'd3;
    end
    return c;
  endfunction

  // starts at a rising edge and returns at the edge that took the push
  task automatic send_cmd(input rvv_pkg::rvv_cmd_t c);
    int waited;
    waited = 0;
    cmd_push <= 1'b1;
    cmd_data <= c;
    @(negedge clk);
    while (cmd_full) begin
      waited++;
      if (waited > 1000) fail_run("command queue stayed full, push never taken");
      else @(negedge clk);
    end
    @(posedge clk);
    cmd_push <= 1'b0;
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_q.size() != 0 || !uop_empty) begin
      waited++;
      if (waited > limit) fail_run($sformatf("%s timed out with uops still due", test_name));
      else @(negedge clk);
    end
    @(posedge clk);
  endtask

  // pop driver
  initial begin
    uop_pop    = 1'b0;
    stall_left = 0;
    forever begin
      @(posedge clk);
      if (pop_mode == 0) begin
        uop_pop <= 1'b0;
      end else if (pop_mode == 1) begin
        uop_pop <= 1'b1;
      end else if (stall_left > 0) begin
        stall_left--;
        uop_pop <= 1'b0;
      end else begin
        uop_pop <= 1'b1;
        if ($urandom_range(0, 7) == 0) begin
          stall_left = $urandom_range(2, 12);
        end
      end
    end
  end

  // sample mid cycle where inputs and outputs are settled
  always @(negedge clk) begin : monitor
    rvv_pkg::rvv_uop_t exp_uop;
    if (!reset && assert_fails() != 0) fail_run("a protocol assertion failed");
    // push taken at the next edge
    if (!reset && cmd_push && !cmd_full) begin
      add_expected(cmd_data);
    end
    if (!reset && uop_pop && !uop_empty) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("%s popped a uop that no command should give", test_name));
      end else begin
        exp_uop = exp_q.pop_front();
        assert (uop_data == exp_uop)
          else fail_run($sformatf("MISMATCH %s expected %h actual %h",
                                  test_name, exp_uop, uop_data));
      end
    end
  end

  initial begin : stimulus
    rvv_pkg::rvv_cmd_t c;
    int                sent;
    logic              full_seen;
    void'($urandom(18));
    reset    = 1'b1;
    cmd_push = 1'b0;
    cmd_data = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (uop_empty === 1'b1 && cmd_full === 1'b0)
      else fail_run($sformatf("MISMATCH %s expected empty=1 full=0 actual empty=%b full=%b",
                              test_name, uop_empty, cmd_full));
    @(posedge clk);

    // every class, sew and lmul
    test_name = "legal_sweep";
    pop_mode  = 1;
    for (int cls = 0; cls < 4; cls++) begin
      for (int sew = 0; sew < 3; sew++) begin
        for (int lmul = 0; lmul < 4; lmul++) begin
          send_cmd(make_cmd(cls, sew, lmul, 0));
        end
      end
    end
    wait_drained(1000);

    // prestart drop with random vstart
    // the last two commands are fully prestart
    test_name = "vstart";
    for (int sew = 0; sew < 3; sew++) begin
      for (int lmul = 0; lmul < 4; lmul++) begin
        send_cmd(make_cmd($urandom_range(0, 3), sew, lmul, $urandom_range(1, 127)));
      end
    end
    send_cmd(make_cmd(3, 1, 3, 63));
    send_cmd(make_cmd(0, 0, 0, 16));
    send_cmd(make_cmd(1, 2, 1, 9));
    wait_drained(1000);

    // illegal ones between legal ones
    test_name = "illegal";
    send_cmd(make_cmd(0, 1, 1, 0));
    c     = make_cmd(0, 0, 0, 0);
    c.sew = 2'd3;
    send_cmd(c);
    send_cmd(make_cmd(2, 0, 2, 0));
    c    = make_cmd(1, 1, 2, 0);
    c.vd = c.vd | 5'd1;
    send_cmd(c);
    c     = make_cmd(2, 0, 3, 0);
    c.vs2 = c.vs2 + 5'd4;
    send_cmd(c);
    send_cmd(make_cmd(3, 2, 0, 0));
    wait_drained(500);

    // fill both queues with pop held low and then drain with stalls
    test_name = "back_pressure";
    pop_mode  = 0;
    sent      = 0;
    full_seen = 1'b0;
    while (!full_seen) begin
      if (sent > 60) begin
        fail_run("command queue never filled while uop pop was held low");
      end else begin
        send_cmd(rand_cmd());
        sent++;
        @(negedge clk);
        full_seen = cmd_full;
        @(posedge clk);
      end
    end
    pop_mode = 2;
    repeat (12) send_cmd(rand_cmd());
    wait_drained(3000);

    // short groups back to back
    test_name = "short_cmds";
    pop_mode  = 1;
    repeat (40) begin
      send_cmd(make_cmd($urandom_range(0, 3), $urandom_range(0, 2), $urandom_range(0, 1), 0));
    end
    wait_drained(1000);

    // mid cycle after the last edge so its assertions have been evaluated
    @(negedge clk);
    if (assert_fails() != 0) begin
      fail_run("a protocol assertion failed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rvv_backend.sv
// vector backend front end, command queue, decode, uop queue
`timescale 1ns/100ps
`default_nettype none

module rvv_backend (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_push,
  input  rvv_pkg::rvv_cmd_t cmd_data,
  input  logic              uop_pop,
  output logic              cmd_full,
  output logic              uop_empty,
  output rvv_pkg::rvv_uop_t uop_data
);

  cq_de_if cq ();
  uq_de_if uq ();

  rvv_cmd_queue i_cmd_queue (
    .clk      (clk),
    .reset    (reset),
    .cmd_push (cmd_push),
    .cmd_data (cmd_data),
    .cmd_full (cmd_full),
    .cq       (cq.queue)
  );

  // combinational from queue head to pop and push
  rvv_decode i_decode (
    .clk   (clk),
    .reset (reset),
    .cq    (cq.decoder),
    .uq    (uq.decoder)
  );

  rvv_uop_queue i_uop_queue (
    .clk       (clk),
    .reset     (reset),
    .uq        (uq.queue),
    .uop_pop   (uop_pop),
    .uop_empty (uop_empty),
    .uop_data  (uop_data)
  );

endmodule

`default_nettype wire

// File: verilog/rvv_cmd_queue.sv
// command fifo, one write port, two head entries visible to decode
`timescale 1ns/100ps
`default_nettype none

module rvv_cmd_queue (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_push,
  input  rvv_pkg::rvv_cmd_t cmd_data,
  output logic              cmd_full,
  cq_de_if.queue            cq
);

  rvv_pkg::rvv_cmd_t            mem [rvv_pkg::CQ_DEPTH];
  logic [rvv_pkg::CQ_AW-1:0]    wptr;
  logic [rvv_pkg::CQ_AW-1:0]    rptr;
  logic [rvv_pkg::CQ_AW:0]      count;
  logic                         push_ok;
  logic [1:0]                   num_pop;

  // push while full is dropped
  assign push_ok = cmd_push && !cmd_full;
  assign num_pop = 2'(cq.pop[0]) + 2'(cq.pop[1]);

  // payload storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wptr] <= cmd_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push_ok) begin
        wptr <= wptr + 1'b1;
      end
      rptr  <= rptr + rvv_pkg::CQ_AW'(num_pop);
      count <= count + (rvv_pkg::CQ_AW + 1)'(push_ok) - (rvv_pkg::CQ_AW + 1)'(num_pop);
    end
  end

  assign cmd_full = count == (rvv_pkg::CQ_AW + 1)'(rvv_pkg::CQ_DEPTH);

  // head entries straight from storage
  assign cq.inst_pkg[0]      = mem[rptr];
  assign cq.inst_pkg[1]      = mem[rptr + 1'b1];
  assign cq.fifo_empty       = count == '0;
  assign cq.almost_empty[1]  = count < 2;

endmodule

`default_nettype wire

// File: verilog/rvv_decode.sv
// decode stage, two decode units and the pop/push controller
`timescale 1ns/100ps
`default_nettype none

module rvv_decode (
  input  logic     clk,
  input  logic     reset,
  cq_de_if.decoder cq,
  uq_de_if.decoder uq
);

  logic [rvv_pkg::NUM_DE_INST-1:0]                                  pkg_valid;
  logic [rvv_pkg::NUM_DE_INST-1:0][rvv_pkg::NUM_DE_UOP-1:0]         uop_valid;
  rvv_pkg::rvv_uop_t [rvv_pkg::NUM_DE_INST-1:0][rvv_pkg::NUM_DE_UOP-1:0] uops;
  rvv_pkg::uop_index_t                                              uop_index_remain;

  // entry 1 present only with two or more held
  assign pkg_valid[0] = !cq.fifo_empty;
  assign pkg_valid[1] = !(cq.fifo_empty || cq.almost_empty[1]);

  // head entry, may resume mid group
  rvv_decode_unit i_decode_unit0 (
    .inst_valid       (pkg_valid[0]),
    .inst             (cq.inst_pkg[0]),
    .uop_index_remain (uop_index_remain),
    .uop_valid        (uop_valid[0]),
    .uops             (uops[0])
  );

  // second entry always starts from uop 0
  rvv_decode_unit i_decode_unit1 (
    .inst_valid       (pkg_valid[1]),
    .inst             (cq.inst_pkg[1]),
    .uop_index_remain ('0),
    .uop_valid        (uop_valid[1]),
    .uops             (uops[1])
  );

  rvv_decode_ctrl i_decode_ctrl (
    .clk              (clk),
    .reset            (reset),
    .pkg_valid        (pkg_valid),
    .uop_valid        (uop_valid),
    .uops             (uops),
    .uop_index_remain (uop_index_remain),
    .cq               (cq),
    .uq               (uq)
  );

endmodule

`default_nettype wire

// File: verilog/rvv_decode_ctrl.sv
// pop and push selection, remaining uop index of a split instruction
`timescale 1ns/100ps
`default_nettype none

module rvv_decode_ctrl (
  input  logic                                                            clk,
  input  logic                                                            reset,
  input  logic [rvv_pkg::NUM_DE_INST-1:0]                                 pkg_valid,
  input  logic [rvv_pkg::NUM_DE_INST-1:0][rvv_pkg::NUM_DE_UOP-1:0]        uop_valid,
  input  rvv_pkg::rvv_uop_t [rvv_pkg::NUM_DE_INST-1:0][rvv_pkg::NUM_DE_UOP-1:0] uops,
  output rvv_pkg::uop_index_t                                             uop_index_remain,
  cq_de_if.decoder                                                        cq,
  uq_de_if.decoder                                                        uq
);

  logic [2:0]                            free_slots;
  logic [rvv_pkg::NUM_DE_INST-1:0][2:0]  num_valid;
  logic [rvv_pkg::NUM_DE_INST-1:0]       has_last;
  logic [2:0]                            take0;
  logic                                  done0;
  logic                                  done1;
  logic [2:0]                            push_cnt;

  // free slots from the thermometer of almost-full levels
  always_comb begin
    if (uq.fifo_full)          free_slots = 3'd0;
    else if (uq.almost_full[1]) free_slots = 3'd1;
    else if (uq.almost_full[2]) free_slots = 3'd2;
    else if (uq.almost_full[3]) free_slots = 3'd3;
    else                        free_slots = 3'd4;
  end

  // valid uops are packed from slot 0 by the units
  always_comb begin
    for (int i = 0; i < rvv_pkg::NUM_DE_INST; i++) begin
      num_valid[i] = '0;
      has_last[i]  = 1'b0;
      for (int j = 0; j < rvv_pkg::NUM_DE_UOP; j++) begin
        num_valid[i] = num_valid[i] + 3'(uop_valid[i][j]);
        has_last[i]  = has_last[i] | (uop_valid[i][j] & uops[i][j].last);
      end
    end
  end

  assign take0 = (num_valid[0] < free_slots) ? num_valid[0] : free_slots;

  // no uops at all means illegal or fully prestart, pop right away
  assign done0 = pkg_valid[0] &&
                 ((num_valid[0] == '0) || (has_last[0] && (num_valid[0] <= free_slots)));

  // second entry only when it finishes whole in the leftover slots
  assign done1 = done0 && pkg_valid[1] &&
                 ((num_valid[1] == '0) ||
                  (has_last[1] && (num_valid[1] <= (free_slots - take0))));

  assign cq.pop   = {done1, done0};
  assign push_cnt = take0 + (done1 ? num_valid[1] : 3'd0);

  // unit 0 uops first, unit 1 uops right behind them
  always_comb begin
    for (int i = 0; i < rvv_pkg::NUM_DE_UOP; i++) begin
      uq.push[i] = 3'(i) < push_cnt;
      uq.data[i] = uops[0][i];
      for (int j = 0; j < rvv_pkg::NUM_DE_UOP; j++) begin
        if (3'(i) == (take0 + 3'(j))) begin
          uq.data[i] = uops[1][j];
        end
      end
    end
  end

  // partly decoded instruction resumes after the uops just pushed
  always_ff @(posedge clk) begin
    if (reset) begin
      uop_index_remain <= '0;
    end else if (done0) begin
      uop_index_remain <= '0;
    end else if (pkg_valid[0] && (num_valid[0] != '0)) begin
      uop_index_remain <= uops[0][0].uop_index + take0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rvv_decode_unit.sv
// splits one vector command into up to four uops
`timescale 1ns/100ps
`default_nettype none

module rvv_decode_unit (
  input  logic                                        inst_valid,
  input  rvv_pkg::rvv_cmd_t                           inst,
  input  rvv_pkg::uop_index_t                         uop_index_remain,
  output logic [rvv_pkg::NUM_DE_UOP-1:0]              uop_valid,
  output rvv_pkg::rvv_uop_t [rvv_pkg::NUM_DE_UOP-1:0] uops
);

  logic [3:0] num_uop;
  logic [4:0] reg_mask;
  logic       legal;
  logic [2:0] epu_shift;
  logic [6:0] first_kept;
  logic [6:0] start;
  logic [7:0] uop_idx   [rvv_pkg::NUM_DE_UOP];
  logic [7:0] elem_base [rvv_pkg::NUM_DE_UOP];

  // register group size, 1 to 8
  assign num_uop  = 4'd1 << inst.lmul;
  assign reg_mask = {1'b0, num_uop - 4'd1};

  // illegal sew or misaligned group is discarded
  assign legal = (inst.sew != 2'd3) &&
                 ((inst.vd & reg_mask) == '0) &&
                 ((inst.vs2 & reg_mask) == '0);

  // log2 of elements per uop, VLENB >> sew
  assign epu_shift = 3'($clog2(rvv_pkg::VLENB)) - {1'b0, inst.sew};

  // uops below this index are all prestart
  assign first_kept = inst.vstart >> epu_shift;

  // resume point, never inside the prestart prefix
  assign start = (first_kept > {4'b0, uop_index_remain}) ?
                 first_kept : {4'b0, uop_index_remain};

  // kept uops come out packed from slot 0
  always_comb begin
    for (int j = 0; j < rvv_pkg::NUM_DE_UOP; j++) begin
      uop_idx[j]   = {1'b0, start} + 8'(j);
      elem_base[j] = uop_idx[j] << epu_shift;
      uop_valid[j] = inst_valid && legal && (uop_idx[j] < {4'b0, num_uop});

      uops[j].inst_class = inst.inst_class;
      uops[j].sew        = inst.sew;
      uops[j].vd         = inst.vd  + {2'b0, uop_idx[j][2:0]};
      uops[j].vs2        = inst.vs2 + {2'b0, uop_idx[j][2:0]};
      uops[j].vs1        = inst.vs1 + {2'b0, uop_idx[j][2:0]};
      uops[j].uop_index  = uop_idx[j][2:0];

      // vstart relative to first element of this uop
      if ({1'b0, inst.vstart} > elem_base[j]) begin
        uops[j].vstart = 7'({1'b0, inst.vstart} - elem_base[j]);
      end else begin
        uops[j].vstart = '0;
      end

      // final uop of the group, only reached when not prestart
      uops[j].last = uop_idx[j] == ({4'b0, num_uop} - 8'd1);
    end
  end

endmodule

`default_nettype wire

// File: verilog/rvv_if.sv
// command queue to decode link
// decode to uop queue link
`timescale 1ns/100ps
`default_nettype none

interface cq_de_if;
  // two oldest entries, entry 1 only meaningful when almost_empty is low
  rvv_pkg::rvv_cmd_t [rvv_pkg::NUM_DE_INST-1:0] inst_pkg;
  logic                                         fifo_empty;
  logic [rvv_pkg::NUM_DE_INST-1:1]              almost_empty;
  // pop[1] only together with pop[0]
  logic [rvv_pkg::NUM_DE_INST-1:0]              pop;

  modport queue (output inst_pkg, output fifo_empty, output almost_empty, input pop);
  modport decoder (input inst_pkg, input fifo_empty, input almost_empty, output pop);
endinterface

interface uq_de_if;
  // push fills from slot 0 upward
  logic [rvv_pkg::NUM_DE_UOP-1:0]               push;
  rvv_pkg::rvv_uop_t [rvv_pkg::NUM_DE_UOP-1:0]  data;
  logic                                         fifo_full;
  // bit i high when fewer than i+1 slots free
  logic [rvv_pkg::NUM_DE_UOP-1:1]               almost_full;

  modport queue (input push, input data, output fifo_full, output almost_full);
  modport decoder (output push, output data, input fifo_full, input almost_full);
endinterface

`default_nettype wire

// File: verilog/rvv_pkg.sv
// shared sizes, field typedefs, instruction class enum
// command and uop layouts for the vector decode path
`default_nettype none

package rvv_pkg;

  // decode throughput per cycle
  localparam int NUM_DE_INST = 2;
  localparam int NUM_DE_UOP  = 4;

  // queue sizes and their pointer widths
  localparam int CQ_DEPTH = 8;
  localparam int CQ_AW    = 3;
  localparam int UQ_DEPTH = 16;
  localparam int UQ_AW    = 4;

  // bytes per vector register, VLEN 128
  localparam int VLENB = 16;

  typedef logic [2:0] uop_index_t;
  typedef logic [4:0] vreg_t;
  typedef logic [6:0] vstart_t;
  typedef logic [1:0] sew_t;   // 0/1/2 = e8/e16/e32, 3 illegal
  typedef logic [1:0] lmul_t;  // log2 of lmul

  typedef enum logic [1:0] {
    arith,
    load_unit,
    load_stride,
    store
  } inst_class_e;

  // vs1 holds the stride register for strided loads
  typedef struct packed {
    inst_class_e inst_class;
    sew_t        sew;
    lmul_t       lmul;
    vreg_t       vd;
    vreg_t       vs2;
    vreg_t       vs1;
    vstart_t     vstart;
  } rvv_cmd_t;

  // register fields already offset by uop_index
  typedef struct packed {
    inst_class_e inst_class;
    sew_t        sew;
    vreg_t       vd;
    vreg_t       vs2;
    vreg_t       vs1;
    uop_index_t  uop_index;
    vstart_t     vstart;
    logic        last;
  } rvv_uop_t;

endpackage

`default_nettype wire

// File: verilog/rvv_uop_queue.sv
// uop fifo, four write ports, one read port
`timescale 1ns/100ps
`default_nettype none

module rvv_uop_queue (
  input  logic              clk,
  input  logic              reset,
  uq_de_if.queue            uq,
  input  logic              uop_pop,
  output logic              uop_empty,
  output rvv_pkg::rvv_uop_t uop_data
);

  rvv_pkg::rvv_uop_t          mem [rvv_pkg::UQ_DEPTH];
  logic [rvv_pkg::UQ_AW-1:0]  wptr;
  logic [rvv_pkg::UQ_AW-1:0]  rptr;
  logic [rvv_pkg::UQ_AW:0]    count;
  logic [2:0]                 num_push;
  logic                       pop_ok;

  // pop on empty is ignored
  assign pop_ok = uop_pop && !uop_empty;

  // push bits are gap free, so a popcount gives the write span
  always_comb begin
    num_push = '0;
    for (int j = 0; j < rvv_pkg::NUM_DE_UOP; j++) begin
      num_push = num_push + 3'(uq.push[j]);
    end
  end

  // consecutive writes from wptr
  always_ff @(posedge clk) begin
    for (int j = 0; j < rvv_pkg::NUM_DE_UOP; j++) begin
      if (uq.push[j]) begin
        mem[wptr + rvv_pkg::UQ_AW'(j)] <= uq.data[j];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      wptr  <= wptr + rvv_pkg::UQ_AW'(num_push);
      rptr  <= rptr + rvv_pkg::UQ_AW'(pop_ok);
      count <= count + (rvv_pkg::UQ_AW + 1)'(num_push) - (rvv_pkg::UQ_AW + 1)'(pop_ok);
    end
  end

  // oldest entry always on the output
  assign uop_empty    = count == '0;
  assign uop_data     = mem[rptr];
  assign uq.fifo_full = count == (rvv_pkg::UQ_AW + 1)'(rvv_pkg::UQ_DEPTH);

  // bit i set when fewer than i+1 slots free
  always_comb begin
    for (int i = 1; i < rvv_pkg::NUM_DE_UOP; i++) begin
      uq.almost_full[i] = ((rvv_pkg::UQ_AW + 1)'(rvv_pkg::UQ_DEPTH) - count) <
                          (rvv_pkg::UQ_AW + 1)'(i + 1);
    end
  end

endmodule

`default_nettype wire
